//--- hdl/pipeline_control_macros.svh
// Pipeline control constants for the reset vector, trap cause codes and CSR addresses
`ifndef PIPELINE_CONTROL_MACROS_SVH
`define PIPELINE_CONTROL_MACROS_SVH

// First fetch address after reset
`define RESET_PC           32'h0000_0200

// Machine CSR addresses reachable through the CSR write strobe
`define CSR_MIE            12'h304
`define CSR_MTVEC          12'h305
`define CSR_MEPC           12'h341

// External interrupt enable position inside mie, and interrupt flag inside mcause
`define MIE_MEIE_BIT       11
`define IRQ_BIT            31

// Exception codes written to the low bits of mcause
`define CAUSE_INSN_MAL     32'd0
`define CAUSE_INSN_FAULT   32'd1
`define CAUSE_ILLEGAL_INSN 32'd2
`define CAUSE_BREAKPOINT   32'd3
`define CAUSE_LOAD_MAL     32'd4
`define CAUSE_LOAD_FAULT   32'd5
`define CAUSE_STORE_MAL    32'd6
`define CAUSE_STORE_FAULT  32'd7
`define CAUSE_ENV_CALL_M   32'd11
`define CAUSE_M_EXT_IRQ    32'd11

`endif

//--- hdl/pipeline_control_pkg.sv
// Shared word, CSR address and trap cause types for the fetch and execute control slice
`default_nettype none

`include "pipeline_control_macros.svh"

package pipeline_control_pkg;

  // Data and address word, used for pc, epc, badaddr and CSR data
  typedef logic [31:0] word_t;

  // Twelve bit CSR address as encoded in the instruction
  typedef logic [11:0] csr_addr_t;

  //////////////////////////////////////////////////
  // Machine trap causes
  //////////////////////////////////////////////////

  // Synchronous exceptions keep bit 31 clear
  // The external interrupt carries the interrupt flag in bit 31
  typedef enum logic [31:0] {
    insn_mal     = `CAUSE_INSN_MAL,
    insn_fault   = `CAUSE_INSN_FAULT,
    illegal_insn = `CAUSE_ILLEGAL_INSN,
    breakpoint   = `CAUSE_BREAKPOINT,
    load_mal     = `CAUSE_LOAD_MAL,
    load_fault   = `CAUSE_LOAD_FAULT,
    store_mal    = `CAUSE_STORE_MAL,
    store_fault  = `CAUSE_STORE_FAULT,
    env_call_m   = `CAUSE_ENV_CALL_M,
    m_ext_irq    = (32'd1 << `IRQ_BIT) | `CAUSE_M_EXT_IRQ
  } cause_t;

endpackage

`default_nettype wire

//--- hdl/hazard_unit.sv
// Hazard unit deciding stall, flush, pc enable and trap routing for the two stage pipeline
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  // Fetch side request and instruction memory status
  input  wire logic                         iren_req,
  input  wire logic                         i_mem_busy,
  // Data access in execute
  input  wire logic                         dren,
  input  wire logic                         dwen,
  input  wire logic                         d_mem_busy,
  // Control flow outcome from execute
  input  wire logic                         jump,
  input  wire logic                         branch,
  input  wire logic                         mispredict,
  input  wire logic                         halt,
  // Exception flags
  input  wire logic                         fault_insn,
  input  wire logic                         mal_insn,
  input  wire logic                         illegal_insn,
  input  wire logic                         fault_l,
  input  wire logic                         mal_l,
  input  wire logic                         fault_s,
  input  wire logic                         mal_s,
  input  wire logic                         breakpoint,
  input  wire logic                         env_m,
  input  wire logic                         ret,
  // Feedback from the machine trap registers
  input  wire logic                         intr,
  input  wire logic                         insert_pc,
  // Exception pc and faulting address per stage
  input  wire pipeline_control_pkg::word_t  epc_f,
  input  wire pipeline_control_pkg::word_t  epc_e,
  input  wire pipeline_control_pkg::word_t  badaddr_f,
  input  wire pipeline_control_pkg::word_t  badaddr_e,
  output logic                              iren,
  output logic                              pc_en,
  output logic                              npc_sel,
  output logic                              if_ex_flush,
  output logic                              if_ex_stall,
  output logic                              wb_enable,
  output logic                              insert_priv_pc,
  output logic                              e_ex_stage,
  output logic                              e_f_stage,
  output logic                              trap_ret,
  output pipeline_control_pkg::word_t       trap_epc,
  output pipeline_control_pkg::word_t       trap_badaddr
);

  // Pipeline hazard terms
  logic dmem_access;
  logic branch_jump;
  logic wait_for_imem;
  logic wait_for_dmem;

  // Trap hazard terms
  logic ex_flush_hazard;
  logic intr_taken;

  //////////////////////////////////////////////////
  // Exception classification
  //////////////////////////////////////////////////

  // Faults raised by the instruction in execute
  assign e_ex_stage = illegal_insn | fault_l | mal_l | fault_s | mal_s |
                      breakpoint | env_m;

  // Faults raised while fetching
  assign e_f_stage = fault_insn | mal_insn;

  // An interrupt only wins when no exception is present in either stage
  assign intr_taken = intr & ~e_ex_stage & ~e_f_stage;

  // Never request a fresh instruction in the cycle an interrupt redirects fetch
  assign iren = iren_req & ~intr_taken;

  //////////////////////////////////////////////////
  // Stall and flush
  //////////////////////////////////////////////////

  assign dmem_access   = dren | dwen;
  assign branch_jump   = jump | (branch & mispredict);
  assign wait_for_imem = iren & i_mem_busy;
  assign wait_for_dmem = dmem_access & d_mem_busy;

  // A resolved branch or jump always fetches from branch_target
  assign npc_sel = branch_jump;

  // Fetch stage faults and interrupts wait for a pending data access to finish
  // Execute stage faults and mret flush at once
  assign ex_flush_hazard = ((intr_taken | e_f_stage) & ~wait_for_dmem) |
                           e_ex_stage | ret;

  // The pc holds on any busy memory or halt, but a redirect always moves it
  assign pc_en = (~wait_for_dmem & ~wait_for_imem & ~halt & ~ex_flush_hazard) |
                 branch_jump | insert_pc | ret;

  // A finished data access while fetch still waits leaves a bubble in the latch
  assign if_ex_flush = ex_flush_hazard | branch_jump |
                       (wait_for_imem & dmem_access & ~d_mem_busy);

  // Busy memory or halt holds the latch unless a trap is flushing it
  assign if_ex_stall = (wait_for_dmem | (wait_for_imem & ~dmem_access) | halt) &
                       (~ex_flush_hazard | e_ex_stage);

  // With two stages a control flow instruction retires even under a stall
  assign wb_enable = ~if_ex_stall | jump | branch;

  //////////////////////////////////////////////////
  // Trap routing to the machine registers
  //////////////////////////////////////////////////

  assign trap_ret       = ret;
  assign insert_priv_pc = insert_pc;

  // Execute faults report the execute pc, everything else the fetch pc
  assign trap_epc = e_ex_stage ? epc_e : epc_f;

  // The faulting address comes from the stage that faulted
  assign trap_badaddr = e_f_stage ? badaddr_f : badaddr_e;

endmodule

`default_nettype wire

//--- hdl/priv_regs.sv
// Machine mode trap registers with trap entry, mret return and trap target selection
`timescale 1ns/1ns
`default_nettype none

`include "pipeline_control_macros.svh"

module priv_regs (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             e_ex_stage,
  input  wire logic                             e_f_stage,
  input  wire logic                             trap_ret,
  input  wire logic                             wb_enable,
  input  wire logic                             ext_irq,
  input  wire pipeline_control_pkg::word_t      trap_epc,
  input  wire pipeline_control_pkg::word_t      trap_badaddr,
  input  wire logic                             fault_insn,
  input  wire logic                             mal_insn,
  input  wire logic                             illegal_insn,
  input  wire logic                             fault_l,
  input  wire logic                             mal_l,
  input  wire logic                             fault_s,
  input  wire logic                             mal_s,
  input  wire logic                             breakpoint,
  input  wire logic                             env_m,
  input  wire logic                             csr_wen,
  input  wire pipeline_control_pkg::csr_addr_t  csr_addr,
  input  wire pipeline_control_pkg::word_t      csr_wdata,
  output logic                                  intr,
  output logic                                  insert_pc,
  output pipeline_control_pkg::word_t           priv_pc,
  output pipeline_control_pkg::cause_t          mcause,
  output pipeline_control_pkg::word_t           mepc
);
  import pipeline_control_pkg::*;

  // Trap vector base, faulting address and external interrupt enable
  word_t  mtvec;
  word_t  mbadaddr;
  logic   mie_meie;

  logic   exception;
  logic   irq_take;
  logic   trap_taken;
  cause_t next_cause;

  //////////////////////////////////////////////////
  // Trap decision
  //////////////////////////////////////////////////

  assign exception = e_ex_stage | e_f_stage;

  // An enabled interrupt is pending only when no exception is present
  assign intr = ext_irq & mie_meie & ~exception;

  // The interrupt enters once the execute instruction is allowed to retire
  assign irq_take   = intr & wb_enable;
  assign trap_taken = exception | irq_take;

  // Trap entry beats mret in the same cycle
  assign insert_pc = trap_taken | trap_ret;
  assign priv_pc   = trap_taken ? mtvec : mepc;

  // Fixed priority, fetch faults first
  // Enum literals are scoped since two of them share a name with the fault ports
  always_comb begin
    if (mal_insn)          next_cause = pipeline_control_pkg::insn_mal;
    else if (fault_insn)   next_cause = pipeline_control_pkg::insn_fault;
    else if (illegal_insn) next_cause = pipeline_control_pkg::illegal_insn;
    else if (breakpoint)   next_cause = pipeline_control_pkg::breakpoint;
    else if (env_m)        next_cause = pipeline_control_pkg::env_call_m;
    else if (mal_l)        next_cause = pipeline_control_pkg::load_mal;
    else if (fault_l)      next_cause = pipeline_control_pkg::load_fault;
    else if (mal_s)        next_cause = pipeline_control_pkg::store_mal;
    else if (fault_s)      next_cause = pipeline_control_pkg::store_fault;
    else                   next_cause = pipeline_control_pkg::m_ext_irq;
  end

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtvec    <= '0;
      mepc     <= '0;
      mbadaddr <= '0;
      mcause   <= pipeline_control_pkg::insn_mal;
      mie_meie <= 1'b0;
    end else begin
      // Software writes land at the next edge
      if (csr_wen) begin
        case (csr_addr)
          `CSR_MTVEC: mtvec    <= csr_wdata;
          `CSR_MIE:   mie_meie <= csr_wdata[`MIE_MEIE_BIT];
          `CSR_MEPC:  mepc     <= csr_wdata;
          default:    ;
        endcase
      end
      // A trap in the same cycle overrides a software write to mepc
      if (trap_taken) begin
        mepc     <= trap_epc;
        mcause   <= next_cause;
        mbadaddr <= trap_badaddr;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_pc.sv
// Program counter register with sequential, branch and trap target selection
`timescale 1ns/1ns
`default_nettype none

`include "pipeline_control_macros.svh"

module fetch_pc (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         pc_en,
  input  wire logic                         npc_sel,
  input  wire logic                         insert_priv_pc,
  input  wire pipeline_control_pkg::word_t  priv_pc,
  input  wire pipeline_control_pkg::word_t  branch_target,
  output pipeline_control_pkg::word_t       pc
);
  import pipeline_control_pkg::*;

  word_t next_pc;

  //////////////////////////////////////////////////
  // Next pc selection
  //////////////////////////////////////////////////

  // Trap entry and mret take priority over a resolved branch
  always_comb begin
    if (insert_priv_pc) begin
      next_pc = priv_pc;
    end else if (npc_sel) begin
      next_pc = branch_target;
    end else begin
      // Sequential fetch of 32 bit instructions
      next_pc = pc + 32'd4;
    end
  end

  // The pc only moves when the hazard logic allows it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RESET_PC;
    end else if (pc_en) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pipeline_control_top.sv
// Fetch and execute control slice joining the hazard unit, trap registers and pc
`timescale 1ns/1ns
`default_nettype none

module pipeline_control_top (
  input  wire logic                             clk,
  input  wire logic                             arst_n,
  input  wire logic                             iren_req,
  input  wire logic                             i_mem_busy,
  input  wire logic                             dren,
  input  wire logic                             dwen,
  input  wire logic                             d_mem_busy,
  input  wire logic                             jump,
  input  wire logic                             branch,
  input  wire logic                             mispredict,
  input  wire pipeline_control_pkg::word_t      branch_target,
  input  wire logic                             halt,
  input  wire logic                             fault_insn,
  input  wire logic                             mal_insn,
  input  wire logic                             illegal_insn,
  input  wire logic                             fault_l,
  input  wire logic                             mal_l,
  input  wire logic                             fault_s,
  input  wire logic                             mal_s,
  input  wire logic                             breakpoint,
  input  wire logic                             env_m,
  input  wire logic                             ret,
  input  wire pipeline_control_pkg::word_t      epc_f,
  input  wire pipeline_control_pkg::word_t      epc_e,
  input  wire pipeline_control_pkg::word_t      badaddr_f,
  input  wire pipeline_control_pkg::word_t      badaddr_e,
  input  wire logic                             ext_irq,
  input  wire logic                             csr_wen,
  input  wire pipeline_control_pkg::csr_addr_t  csr_addr,
  input  wire pipeline_control_pkg::word_t      csr_wdata,
  output pipeline_control_pkg::word_t           pc,
  output logic                                  iren,
  output logic                                  if_ex_stall,
  output logic                                  if_ex_flush,
  output logic                                  wb_enable,
  output pipeline_control_pkg::cause_t          mcause,
  output pipeline_control_pkg::word_t           mepc
);
  import pipeline_control_pkg::*;

  // Hazard decisions toward the pc register
  logic  pc_en;
  logic  npc_sel;
  logic  insert_priv_pc;

  // Trap handshake between hazard unit and machine registers
  logic  e_ex_stage;
  logic  e_f_stage;
  logic  trap_ret;
  logic  intr;
  logic  insert_pc;
  word_t trap_epc;
  word_t trap_badaddr;
  word_t priv_pc;

  //////////////////////////////////////////////////
  // Block instances
  //////////////////////////////////////////////////

  hazard_unit u_hazard_unit (
    .iren_req       (iren_req),
    .i_mem_busy     (i_mem_busy),
    .dren           (dren),
    .dwen           (dwen),
    .d_mem_busy     (d_mem_busy),
    .jump           (jump),
    .branch         (branch),
    .mispredict     (mispredict),
    .halt           (halt),
    .fault_insn     (fault_insn),
    .mal_insn       (mal_insn),
    .illegal_insn   (illegal_insn),
    .fault_l        (fault_l),
    .mal_l          (mal_l),
    .fault_s        (fault_s),
    .mal_s          (mal_s),
    .breakpoint     (breakpoint),
    .env_m          (env_m),
    .ret            (ret),
    .intr           (intr),
    .insert_pc      (insert_pc),
    .epc_f          (epc_f),
    .epc_e          (epc_e),
    .badaddr_f      (badaddr_f),
    .badaddr_e      (badaddr_e),
    .iren           (iren),
    .pc_en          (pc_en),
    .npc_sel        (npc_sel),
    .if_ex_flush    (if_ex_flush),
    .if_ex_stall    (if_ex_stall),
    .wb_enable      (wb_enable),
    .insert_priv_pc (insert_priv_pc),
    .e_ex_stage     (e_ex_stage),
    .e_f_stage      (e_f_stage),
    .trap_ret       (trap_ret),
    .trap_epc       (trap_epc),
    .trap_badaddr   (trap_badaddr)
  );

  // Trap state sits beside the hazard logic and feeds back intr and insert_pc
  priv_regs u_priv_regs (
    .clk          (clk),
    .arst_n       (arst_n),
    .e_ex_stage   (e_ex_stage),
    .e_f_stage    (e_f_stage),
    .trap_ret     (trap_ret),
    .wb_enable    (wb_enable),
    .ext_irq      (ext_irq),
    .trap_epc     (trap_epc),
    .trap_badaddr (trap_badaddr),
    .fault_insn   (fault_insn),
    .mal_insn     (mal_insn),
    .illegal_insn (illegal_insn),
    .fault_l      (fault_l),
    .mal_l        (mal_l),
    .fault_s      (fault_s),
    .mal_s        (mal_s),
    .breakpoint   (breakpoint),
    .env_m        (env_m),
    .csr_wen      (csr_wen),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .intr         (intr),
    .insert_pc    (insert_pc),
    .priv_pc      (priv_pc),
    .mcause       (mcause),
    .mepc         (mepc)
  );

  fetch_pc u_fetch_pc (
    .clk            (clk),
    .arst_n         (arst_n),
    .pc_en          (pc_en),
    .npc_sel        (npc_sel),
    .insert_priv_pc (insert_priv_pc),
    .priv_pc        (priv_pc),
    .branch_target  (branch_target),
    .pc             (pc)
  );

endmodule

`default_nettype wire

//--- verification/pipeline_control_assertions.sv
// Concurrent checks on the hazard decisions of the pipeline control slice
`timescale 1ns/1ns
`default_nettype none

module pipeline_control_assertions (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic npc_sel,
  input wire logic pc_en,
  input wire logic if_ex_flush,
  input wire logic intr,
  input wire logic iren
);

  //////////////////////////////////////////////////
  // Hazard rules
  //////////////////////////////////////////////////

  // A resolved branch or jump moves the pc while it flushes the latch
  a_branch_moves_pc: assert property (@(posedge clk) disable iff (!arst_n)
    (npc_sel && if_ex_flush) |-> pc_en)
    else $error("Branch flush while pc_en is low");

  // The wrong path after a branch never stays in the latch
  a_branch_flushes: assert property (@(posedge clk) disable iff (!arst_n)
    npc_sel |-> if_ex_flush)
    else $error("Branch redirect without a flush");

  // No fetch request goes out while an interrupt redirects fetch
  a_irq_gates_fetch: assert property (@(posedge clk) disable iff (!arst_n)
    intr |-> !iren)
    else $error("Instruction fetch requested during an interrupt");

endmodule

// The hazard outputs and the clock meet in the top level
bind pipeline_control_top pipeline_control_assertions i_assertions (
  .clk         (clk),
  .arst_n      (arst_n),
  .npc_sel     (npc_sel),
  .pc_en       (pc_en),
  .if_ex_flush (if_ex_flush),
  .intr        (intr),
  .iren        (iren)
);

`default_nettype wire

//--- verification/tb_pipeline_control.sv
// Data driven testbench for the fetch and execute pipeline control slice
`timescale 1ns/1ns
`default_nettype none

`include "pipeline_control_macros.svh"

module tb_pipeline_control;
  import pipeline_control_pkg::*;

  // Ten words per vector, inputs first and expected values after them
  localparam int FIELDS      = 10;
  localparam int MAX_VECTORS = 64;
  localparam int DEPTH       = FIELDS * MAX_VECTORS;
  localparam int AW          = $clog2(DEPTH);
  localparam word_t END_MARKER = 32'hffff_ffff;

  // Word positions inside one vector
  localparam int F_FLAGS     = 0;
  localparam int F_TARGET    = 1;
  localparam int F_EPC       = 2;
  localparam int F_CSR_ADDR  = 3;
  localparam int F_CSR_WDATA = 4;
  localparam int F_PC        = 5;
  localparam int F_FLUSH     = 6;
  localparam int F_STALL     = 7;
  localparam int F_MCAUSE    = 8;
  localparam int F_MEPC      = 9;

  logic      clk;
  logic      arst_n;
  logic      iren_req, i_mem_busy;
  logic      dren, dwen, d_mem_busy;
  logic      jump, branch, mispredict, halt;
  logic      fault_insn, mal_insn, illegal_insn, fault_l, mal_l;
  logic      fault_s, mal_s, breakpoint, env_m, ret;
  logic      ext_irq, csr_wen;
  word_t     branch_target, epc_f, epc_e, badaddr_f, badaddr_e, csr_wdata;
  csr_addr_t csr_addr;

  // Observed outputs of the control slice
  word_t     pc;
  logic      iren, if_ex_stall, if_ex_flush, wb_enable;
  word_t     mcause;
  word_t     mepc;

  word_t     stim_mem [0:DEPTH-1];
  int        error_count;
  int        check_count;
  int        vec_idx;
  bit        done;

  // Interrupt enable as software last wrote it through mie
  logic      irq_enabled;

  pipeline_control_top i_dut (.*);

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic word_t vector_field(input int vec, input int pos);
    return stim_mem[AW'(vec * FIELDS + pos)];
  endfunction

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error: vector %0d %s is 0x%h, expected 0x%h",
               vec_idx, name, actual, expected);
    end
  endtask

  // Flag bit n of the first word drives one single bit input
  task automatic apply_vector(input int vec);
    word_t flags;
    word_t epc;
    word_t ex_pc;
    word_t f_pc;
    flags = vector_field(vec, F_FLAGS);
    epc   = vector_field(vec, F_EPC);
    // The epc field belongs to the trapping stage, fetch runs one word ahead of execute
    if (|flags[17:11]) begin
      ex_pc = epc;
      f_pc  = epc + 32'd4;
    end else begin
      f_pc  = epc;
      ex_pc = epc - 32'd4;
    end
    iren_req      <= flags[0];
    i_mem_busy    <= flags[1];
    dren          <= flags[2];
    dwen          <= flags[3];
    d_mem_busy    <= flags[4];
    jump          <= flags[5];
    branch        <= flags[6];
    mispredict    <= flags[7];
    halt          <= flags[8];
    fault_insn    <= flags[9];
    mal_insn      <= flags[10];
    illegal_insn  <= flags[11];
    fault_l       <= flags[12];
    mal_l         <= flags[13];
    fault_s       <= flags[14];
    mal_s         <= flags[15];
    breakpoint    <= flags[16];
    env_m         <= flags[17];
    ret           <= flags[18];
    ext_irq       <= flags[19];
    csr_wen       <= flags[20];
    branch_target <= vector_field(vec, F_TARGET);
    // Each stage reports its own pc, which doubles as its faulting address
    epc_f         <= f_pc;
    epc_e         <= ex_pc;
    badaddr_f     <= f_pc;
    badaddr_e     <= ex_pc;
    csr_addr      <= csr_addr_t'(vector_field(vec, F_CSR_ADDR));
    csr_wdata     <= vector_field(vec, F_CSR_WDATA);
  endtask

  // Expected values describe the cycle in which the vector is applied
  task automatic check_vector(input int vec);
    word_t flags;
    logic  irq_pending;
    logic  exp_iren;
    logic  exp_wb_enable;
    flags = vector_field(vec, F_FLAGS);
    // An enabled interrupt with no exception in either stage blocks the fetch request
    irq_pending   = flags[19] & irq_enabled & ~(|flags[17:9]);
    exp_iren      = flags[0] & ~irq_pending;
    // The execute instruction retires unless the latch holds, control flow always retires
    exp_wb_enable = (vector_field(vec, F_STALL) == '0) | flags[5] | flags[6];
    check_value("pc", pc, vector_field(vec, F_PC));
    check_value("if_ex_flush", 32'(if_ex_flush), vector_field(vec, F_FLUSH));
    check_value("if_ex_stall", 32'(if_ex_stall), vector_field(vec, F_STALL));
    check_value("mcause", mcause, vector_field(vec, F_MCAUSE));
    check_value("mepc", mepc, vector_field(vec, F_MEPC));
    check_value("iren", 32'(iren), 32'(exp_iren));
    check_value("wb_enable", 32'(wb_enable), 32'(exp_wb_enable));
  endtask

  // A write to mie changes the interrupt enable from the next cycle on
  task automatic update_irq_enable(input int vec);
    word_t flags;
    word_t wdata;
    flags = vector_field(vec, F_FLAGS);
    wdata = vector_field(vec, F_CSR_WDATA);
    if (flags[20] && csr_addr_t'(vector_field(vec, F_CSR_ADDR)) == `CSR_MIE) begin
      irq_enabled = wdata[`MIE_MEIE_BIT];
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    arst_n = 1'b0;
    {iren_req, i_mem_busy, dren, dwen, d_mem_busy} = '0;
    {jump, branch, mispredict, halt} = '0;
    {fault_insn, mal_insn, illegal_insn, fault_l, mal_l} = '0;
    {fault_s, mal_s, breakpoint, env_m, ret, ext_irq, csr_wen} = '0;
    {branch_target, epc_f, epc_e, badaddr_f, badaddr_e, csr_wdata} = '0;
    csr_addr    = '0;
    error_count = 0;
    check_count = 0;
    vec_idx     = 0;
    done        = 1'b0;
    irq_enabled = 1'b0;
    $readmemh("verification/pipeline_control_stimulus.txt", stim_mem);

    // Reset for two cycles, the first vector goes out on the release edge
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // Walk the vectors, bounded by the size of the stimulus memory
    while (!done && vec_idx < MAX_VECTORS) begin
      if (vector_field(vec_idx, F_FLAGS) == END_MARKER) begin
        done = 1'b1;
      end else begin
        apply_vector(vec_idx);
        @(negedge clk);
        check_vector(vec_idx);
        update_irq_enable(vec_idx);
        @(posedge clk);
        vec_idx++;
      end
    end

    if (!done) begin
      error_count++;
      $display("Stimulus file has no end marker within %0d vectors", MAX_VECTORS);
    end
    $display("Vectors: %0d, checks: %0d, errors: %0d", vec_idx, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/pipeline_control_stimulus.txt
// flags target epc csr_addr csr_wdata | expected pc if_ex_flush if_ex_stall mcause mepc
// flags: b0 iren_req b1 i_mem_busy b2 dren b3 dwen b4 d_mem_busy b5 jump b6 branch b7 mispredict
// b8 halt b9 fault_insn b10 mal_insn b11 illegal_insn b18 ret b19 ext_irq b20 csr_wen
// Idle fetch from the reset vector
000001 00000000 00000000 000 00000000 00000200 0 0 00000000 00000000
000001 00000000 00000000 000 00000000 00000204 0 0 00000000 00000000
000001 00000000 00000000 000 00000000 00000208 0 0 00000000 00000000
// Busy instruction and data memory, then a fetch wait after a finished load
000003 00000000 00000000 000 00000000 0000020c 0 1 00000000 00000000
000003 00000000 00000000 000 00000000 0000020c 0 1 00000000 00000000
000015 00000000 00000000 000 00000000 0000020c 0 1 00000000 00000000
000005 00000000 00000000 000 00000000 0000020c 0 0 00000000 00000000
000007 00000000 00000000 000 00000000 00000210 1 0 00000000 00000000
// Mispredicted branch, jump, and a correctly predicted branch
0000c1 00000400 00000000 000 00000000 00000210 1 0 00000000 00000000
000021 00000500 00000000 000 00000000 00000400 1 0 00000000 00000000
000041 00000900 00000000 000 00000000 00000500 0 0 00000000 00000000
// mtvec write, illegal instruction, then mret
100001 00000000 00000000 305 00000800 00000504 0 0 00000000 00000000
000801 00000000 00000508 000 00000000 00000508 1 0 00000000 00000000
000001 00000000 00000000 000 00000000 00000800 0 0 00000002 00000508
040001 00000000 00000000 000 00000000 00000804 1 0 00000002 00000508
000001 00000000 00000000 000 00000000 00000508 0 0 00000002 00000508
// Interrupt masked, enabled through mie, then taken
080001 00000000 00000000 000 00000000 0000050c 0 0 00000002 00000508
100001 00000000 00000000 304 00000800 00000510 0 0 00000002 00000508
080001 00000000 00000514 000 00000000 00000514 1 0 00000002 00000508
000001 00000000 00000000 000 00000000 00000800 0 0 8000000b 00000514
// Halt, then an instruction fetch fault
000101 00000000 00000000 000 00000000 00000804 0 1 8000000b 00000514
000001 00000000 00000000 000 00000000 00000804 0 0 8000000b 00000514
000201 00000000 00000808 000 00000000 00000808 1 0 8000000b 00000514
000001 00000000 00000000 000 00000000 00000800 0 0 00000001 00000808
ffffffff

//--- verilog.f
+incdir+hdl
hdl/pipeline_control_pkg.sv
hdl/hazard_unit.sv
hdl/priv_regs.sv
hdl/fetch_pc.sv
hdl/pipeline_control_top.sv
verification/pipeline_control_assertions.sv
verification/tb_pipeline_control.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_pipeline_control
FILELIST = verilog.f
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(filter-out +%,$(shell cat $(FILELIST))) hdl/pipeline_control_macros.svh
STIMULUS = verification/pipeline_control_stimulus.txt

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM) $(STIMULUS)
	./$(SIM) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
